/* filelist.f */
+incdir+hdl
hdl/spi_bus_pkg.sv
hdl/spi_core_pkg.sv
hdl/spi_slave_io.sv
hdl/spi_slave_ctrl.sv
hdl/spi_slave_regs.sv
hdl/spi_slave.sv
dv/spi_clk_gen.sv
dv/tb_spi_slave.sv

/* dv/tb_spi_slave.sv */
// spi slave testbench, directed register map tests through a mode 0 master model
`timescale 1ns/1ns
`include "spi_slave_macros.svh"

module tb_spi_slave;

   // about 75 frame bytes of 64 cycles plus frame gaps, four times over
   localparam int MAX_CYCLES = 20000;
   // half sck period in spi_clk cycles
   localparam int HALF = 4;

   logic                       spi_clk;
   logic                       nreset;
   logic                       sck;
   logic                       ss;
   logic                       mosi;
   logic                       miso;
   logic                       core_access;
   spi_core_pkg::core_pkt_t    core_packet;
   logic [`SPI_NREGS*8-1:0]    spi_regs;
   logic [7:0]                 tx_buf [0:15];
   logic [7:0]                 rx_buf [0:15];
   logic [7:0]                 user_exp [0:7];
   logic [7:0]                 cmd_exp;
   int                         errors = 0;
   int                         checks = 0;
   int                         cycles = 0;

   spi_clk_gen u_clk (.spi_clk(spi_clk), .nreset(nreset));

   spi_slave DUT
   (
      .spi_clk     (spi_clk),
      .nreset      (nreset),
      .sck         (sck),
      .ss          (ss),
      .mosi        (mosi),
      .miso        (miso),
      .core_access (core_access),
      .core_packet (core_packet),
      .spi_regs    (spi_regs)
   );

   //##########################################################################
   // helpers
   //##########################################################################

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge spi_clk);
   endtask

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERR time=%0t signal=%s got=%h exp=%h", $time, name, got, exp);
      end
   endtask

   // register n straight off the concatenated vector
   function automatic logic [7:0] view_reg(input int n);
      return spi_regs[n*8 +: 8];
   endfunction

   // first frame byte built from the bus package layout
   function automatic logic [7:0] header_byte(input logic rd, input logic [`SPI_AW-1:0] addr);
      spi_bus_pkg::spi_hdr_t hdr;
      hdr.rd    = rd;
      hdr.spare = 1'b0;
      hdr.addr  = addr;
      return hdr;
   endfunction

   // mode 0 byte shift with mosi set while sck is low
   // miso taken just ahead of each rising edge
   task automatic shift_byte(input logic [7:0] b, input int nbits, output logic [7:0] r);
      r = 8'h00;
      for (int i = 0; i < nbits; i++)
      begin
         mosi = b[7-i];
         wait_cycles(HALF);
         r   = {r[6:0], miso};
         sck = 1'b1;
         wait_cycles(HALF);
         sck = 1'b0;
      end
   endtask

   // header and data from tx_buf with miso bytes collected in rx_buf
   task automatic spi_frame(input int nbytes);
      ss = 1'b0;
      wait_cycles(HALF);
      for (int i = 0; i < nbytes; i++)
         shift_byte(tx_buf[i], 8, rx_buf[i]);
      wait_cycles(HALF);
      ss   = 1'b1;
      mosi = 1'b0;
      // room for the last write to land
      wait_cycles(8);
   endtask

   // data bytes already in tx_buf[1..n]
   task automatic write_burst(input logic [5:0] addr, input int n);
      tx_buf[0] = header_byte(1'b0, addr);
      spi_frame(n + 1);
   endtask

   task automatic read_burst(input logic [5:0] addr, input int n);
      tx_buf[0] = header_byte(1'b1, addr);
      for (int i = 1; i <= n; i++)
         tx_buf[i] = 8'h00;
      spi_frame(n + 1);
   endtask

   task automatic write_reg(input logic [5:0] addr, input logic [7:0] data);
      tx_buf[1] = data;
      write_burst(addr, 1);
   endtask

   // one cycle strobe from the core side
   task automatic core_write(input logic wr, input logic [31:0] src, input logic [31:0] dat);
      core_packet = '{write: wr, srcaddr: src, data: dat};
      core_access = 1'b1;
      wait_cycles(1);
      core_access = 1'b0;
      core_packet = '0;
      wait_cycles(2);
   endtask

   //##########################################################################
   // directed tests
   //##########################################################################

   // only psize is nonzero after reset
   task automatic reset_map_readback();
      logic [7:0] exp;
      read_burst(6'd0, 8);
      for (int i = 0; i < 8; i++)
      begin
         exp = (i == 3) ? 8'd104 : 8'h00;
         check_val($sformatf("rd_data[%0d]", i), rx_buf[i+1], exp);
      end
   endtask

   task automatic cmd_psize_roundtrip();
      logic [7:0] psize_v;
      cmd_exp   = 8'($urandom);
      psize_v   = 8'($urandom);
      tx_buf[1] = cmd_exp;
      tx_buf[2] = psize_v;
      write_burst(6'd2, 2);
      check_val("spi_regs[cmd]", view_reg(2), cmd_exp);
      check_val("spi_regs[psize]", view_reg(3), psize_v);
      read_burst(6'd2, 2);
      check_val("rd_data[cmd]", rx_buf[1], cmd_exp);
      check_val("rd_data[psize]", rx_buf[2], psize_v);
   endtask

   // user bytes hidden from reads until config bit 0 is set
   task automatic user_space_visibility();
      for (int i = 0; i < 8; i++)
      begin
         user_exp[i] = 8'($urandom);
         tx_buf[i+1] = user_exp[i];
      end
      write_burst(6'd16, 8);
      for (int i = 0; i < 8; i++)
         check_val($sformatf("spi_regs[%0d]", 16 + i), view_reg(16 + i), user_exp[i]);
      read_burst(6'd16, 8);
      for (int i = 0; i < 8; i++)
         check_val($sformatf("rd_data[%0d] hidden", 16 + i), rx_buf[i+1], 8'h00);
      write_reg(6'd0, 8'h01);
      read_burst(6'd16, 8);
      for (int i = 0; i < 8; i++)
         check_val($sformatf("rd_data[%0d]", 16 + i), rx_buf[i+1], user_exp[i]);
      write_reg(6'd0, 8'h00);
   endtask

   // data low word at register 8 with source address above it
   task automatic core_writeback();
      logic [31:0] src;
      logic [31:0] dat;
      logic [63:0] exp;
      src = $urandom;
      dat = $urandom;
      exp = {src, dat};
      core_write(1'b1, src, dat);
      check_val("spi_regs[core]", spi_regs[64 +: 64], exp);
      check_val("spi_regs[status]", view_reg(1), 8'h01);
      read_burst(6'd8, 8);
      for (int k = 0; k < 8; k++)
         check_val($sformatf("rd_data[%0d]", 8 + k), rx_buf[k+1], exp[8*k +: 8]);
      // read clears status
      read_burst(6'd1, 1);
      check_val("rd_data[status] first", rx_buf[1], 8'h01);
      read_burst(6'd1, 1);
      check_val("rd_data[status] second", rx_buf[1], 8'h00);
      // write flag clear leaves everything alone
      core_write(1'b0, ~src, ~dat);
      check_val("spi_regs[core] no write", spi_regs[64 +: 64], exp);
      check_val("spi_regs[status] no write", view_reg(1), 8'h00);
   endtask

   task automatic spi_disable_lock();
      write_reg(6'd0, 8'h02);
      check_val("spi_regs[config] dis", view_reg(0), 8'h02);
      write_reg(6'd2, ~cmd_exp);
      check_val("spi_regs[cmd] dis", view_reg(2), cmd_exp);
      // config still reachable while disabled
      write_reg(6'd0, 8'h00);
      check_val("spi_regs[config] en", view_reg(0), 8'h00);
      read_burst(6'd0, 1);
      check_val("rd_data[config]", rx_buf[1], 8'h00);
   endtask

   // ss raised mid byte before a clean frame
   task automatic partial_byte_discard();
      logic [7:0] r;
      ss = 1'b0;
      wait_cycles(HALF);
      shift_byte(header_byte(1'b0, 6'd2), 8, r);
      shift_byte(~cmd_exp, 4, r);
      wait_cycles(HALF);
      ss   = 1'b1;
      mosi = 1'b0;
      wait_cycles(8);
      check_val("spi_regs[cmd] partial", view_reg(2), cmd_exp);
      cmd_exp = 8'($urandom);
      write_reg(6'd2, cmd_exp);
      check_val("spi_regs[cmd] after", view_reg(2), cmd_exp);
      read_burst(6'd2, 1);
      check_val("rd_data[cmd] after", rx_buf[1], cmd_exp);
   endtask

   //##########################################################################
   // run control
   //##########################################################################

   always @(posedge spi_clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("timeout, test sequence still running after %0d cycles", cycles);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   initial
   begin
      sck         = 1'b0;
      ss          = 1'b1;
      mosi        = 1'b0;
      core_access = 1'b0;
      core_packet = '0;
      void'($urandom(14034));
      @(posedge nreset);
      wait_cycles(4);
      reset_map_readback();
      cmd_psize_roundtrip();
      user_space_visibility();
      core_writeback();
      spi_disable_lock();
      partial_byte_discard();
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

/* dv/spi_clk_gen.sv */
// testbench clock and reset source for the spi slave, 8 ns clock and 16 cycle reset
`timescale 1ns/1ns

module spi_clk_gen
#(
   parameter int PERIOD       = 8,
   parameter int RESET_CYCLES = 16
)
(
   output logic spi_clk,
   output logic nreset
);

   // free running clock
   initial
   begin
      spi_clk = 1'b0;
      forever
         #(PERIOD/2) spi_clk = ~spi_clk;
   end

   // reset released on a falling edge like every other input
   initial
   begin
      nreset = 1'b0;
      repeat (RESET_CYCLES) @(posedge spi_clk);
      @(negedge spi_clk);
      nreset = 1'b1;
   end

endmodule

/* hdl/spi_slave.sv */
// spi slave top, pin interface, frame control and register file
`timescale 1ns/1ns
`include "spi_slave_macros.svh"

module spi_slave
(
   input  logic                      spi_clk,
   input  logic                      nreset,
   input  logic                      sck,
   input  logic                      ss,
   input  logic                      mosi,
   output logic                      miso,
   input  logic                      core_access,
   input  spi_core_pkg::core_pkt_t   core_packet,
   output logic [`SPI_NREGS*8-1:0]   spi_regs
);

   logic                    frame_start;
   logic                    byte_done;
   logic [7:0]              rx_byte;
   logic                    tx_load;
   logic [7:0]              rd_data;
   spi_bus_pkg::reg_wr_t    reg_wr;
   spi_bus_pkg::reg_rd_t    reg_rd;

   //##########################################################################
   // io to ctrl to regs, read data back to io
   //##########################################################################

   spi_slave_io u_io
   (
      .spi_clk     (spi_clk),
      .nreset      (nreset),
      .sck         (sck),
      .ss          (ss),
      .mosi        (mosi),
      .miso        (miso),
      .frame_start (frame_start),
      .byte_done   (byte_done),
      .rx_byte     (rx_byte),
      .tx_load     (tx_load),
      .tx_byte     (rd_data)
   );

   spi_slave_ctrl u_ctrl
   (
      .spi_clk     (spi_clk),
      .nreset      (nreset),
      .frame_start (frame_start),
      .byte_done   (byte_done),
      .rx_byte     (rx_byte),
      .tx_load     (tx_load),
      .reg_wr      (reg_wr),
      .reg_rd      (reg_rd)
   );

   spi_slave_regs u_regs
   (
      .spi_clk     (spi_clk),
      .nreset      (nreset),
      .reg_wr      (reg_wr),
      .reg_rd      (reg_rd),
      .core_access (core_access),
      .core_packet (core_packet),
      .rd_data     (rd_data),
      .spi_regs    (spi_regs)
   );

endmodule

/* hdl/spi_slave_regs.sv */
// spi slave register file with control, core data and user space
`timescale 1ns/1ns
`include "spi_slave_macros.svh"

module spi_slave_regs
(
   input  logic                         spi_clk,
   input  logic                         nreset,
   input  spi_bus_pkg::reg_wr_t         reg_wr,
   input  spi_bus_pkg::reg_rd_t         reg_rd,
   input  logic                         core_access,
   input  spi_core_pkg::core_pkt_t      core_packet,
   output logic [7:0]                   rd_data,
   output logic [`SPI_NREGS*8-1:0]      spi_regs
);

   localparam int NUSER = `SPI_NREGS - `SPI_USER_BASE;

   logic [7:0]              spi_config;
   logic [7:0]              spi_status;
   logic [7:0]              spi_cmd;
   logic [7:0]              spi_psize;
   logic [2*`CORE_AW-1:0]   core_regs;
   logic [7:0]              user_mem [NUSER];
   logic                    spi_dis;
   logic                    wr_ok;
   logic                    wr_config;
   logic                    wr_cmd;
   logic                    wr_psize;
   logic                    wr_user;
   logic                    core_wr;
   logic                    rd_status;
   logic [`SPI_AW-1:0]      user_wr_idx;
   logic [`SPI_AW-1:0]      user_rd_idx;
   logic [2:0]              core_rd_idx;

   //##########################################################################
   // decode
   //##########################################################################

   // config stays writable so the port can be turned back on
   assign spi_dis     = spi_config[`CONFIG_SPI_DIS];
   assign wr_ok       = reg_wr.valid & ~spi_dis;
   assign wr_config   = reg_wr.valid & (reg_wr.addr == `SPI_CONFIG);
   assign wr_cmd      = wr_ok & (reg_wr.addr == `SPI_CMD);
   assign wr_psize    = wr_ok & (reg_wr.addr == `SPI_PSIZE);
   assign wr_user     = wr_ok & (reg_wr.addr >= `SPI_USER_BASE);
   assign core_wr     = core_access & core_packet.write;
   assign rd_status   = reg_rd.valid & (reg_rd.addr == `SPI_STATUS);
   assign user_wr_idx = reg_wr.addr - `SPI_USER_BASE;
   assign user_rd_idx = reg_rd.addr - `SPI_USER_BASE;
   assign core_rd_idx = 3'(reg_rd.addr - `SPI_CORE_BASE);

   //##########################################################################
   // control registers
   //##########################################################################

   // status set by core wins over a clearing read
   always_ff @(posedge spi_clk or negedge nreset)
      if (!nreset)
      begin
         spi_config <= 8'h00;
         spi_status <= 8'h00;
         spi_cmd    <= 8'h00;
         spi_psize  <= 8'(`SPI_PSIZE_RESET);
         core_regs  <= '0;
      end
      else
      begin
         if (wr_config)
            spi_config <= reg_wr.data;
         if (wr_cmd)
            spi_cmd <= reg_wr.data;
         if (wr_psize)
            spi_psize <= reg_wr.data;
         if (core_wr)
            spi_status <= 8'h01;
         else if (rd_status)
            spi_status <= 8'h00;
         // data in the low half
         if (core_wr)
            core_regs <= {core_packet.srcaddr, core_packet.data};
      end

   // user bytes
   always_ff @(posedge spi_clk)
      if (wr_user)
         user_mem[user_wr_idx] <= reg_wr.data;

   //##########################################################################
   // readback
   //##########################################################################

   // reserved reads zero, user space only when enabled
   always_comb
   begin
      rd_data = 8'h00;
      if (reg_rd.addr >= `SPI_USER_BASE)
      begin
         if (spi_config[`CONFIG_USER_EN])
            rd_data = user_mem[user_rd_idx];
      end
      else if (reg_rd.addr >= `SPI_CORE_BASE)
         rd_data = core_regs[core_rd_idx*8 +: 8];
      else
         case (reg_rd.addr)
            `SPI_CONFIG: rd_data = spi_config;
            `SPI_STATUS: rd_data = spi_status;
            `SPI_CMD:    rd_data = spi_cmd;
            `SPI_PSIZE:  rd_data = spi_psize;
            default:     rd_data = 8'h00;
         endcase
   end

   // register n at bits 8n+7 down to 8n, user bytes always visible
   always_comb
   begin
      spi_regs = '0;
      spi_regs[`SPI_CONFIG*8 +: 8]              = spi_config;
      spi_regs[`SPI_STATUS*8 +: 8]              = spi_status;
      spi_regs[`SPI_CMD*8 +: 8]                 = spi_cmd;
      spi_regs[`SPI_PSIZE*8 +: 8]               = spi_psize;
      spi_regs[`SPI_CORE_BASE*8 +: 2*`CORE_AW]  = core_regs;
      for (int i = 0; i < NUSER; i++)
         spi_regs[(`SPI_USER_BASE+i)*8 +: 8] = user_mem[i];
   end

endmodule

/* hdl/spi_slave_ctrl.sv */
// spi slave frame control, header decode and auto incrementing address
`timescale 1ns/1ns
`include "spi_slave_macros.svh"

module spi_slave_ctrl
(
   input  logic                   spi_clk,
   input  logic                   nreset,
   input  logic                   frame_start,
   input  logic                   byte_done,
   input  logic [7:0]             rx_byte,
   output logic                   tx_load,
   output spi_bus_pkg::reg_wr_t   reg_wr,
   output spi_bus_pkg::reg_rd_t   reg_rd
);

   typedef enum logic [1:0]
   {
      st_idle,
      st_hdr,
      st_data
   } state_t;

   state_t                  state;
   spi_bus_pkg::spi_hdr_t   hdr_in;
   logic                    rd_frame;
   logic [`SPI_AW-1:0]      addr;
   logic [`SPI_AW-1:0]      addr_inc;

   // header view of the received byte
   assign hdr_in   = rx_byte;

   // wraps from 63 back to 0
   assign addr_inc = addr + 1'b1;

   //##########################################################################
   // frame state machine
   //##########################################################################

   // frame_start always restarts at the header
   // read frames fetch ahead one byte, tx_load follows each reg_rd
   always_ff @(posedge spi_clk or negedge nreset)
      if (!nreset)
      begin
         state    <= st_idle;
         rd_frame <= 1'b0;
         addr     <= '0;
         reg_wr   <= '0;
         reg_rd   <= '0;
         tx_load  <= 1'b0;
      end
      else
      begin
         // strobes are single cycle
         reg_wr.valid <= 1'b0;
         reg_rd.valid <= 1'b0;
         tx_load      <= reg_rd.valid;
         if (frame_start)
            state <= st_hdr;
         else if (byte_done)
            case (state)
               st_hdr:
               begin
                  rd_frame <= hdr_in.rd;
                  addr     <= hdr_in.addr;
                  state    <= st_data;
                  // first read byte goes out with the next byte
                  if (hdr_in.rd)
                     reg_rd <= '{valid: 1'b1, addr: hdr_in.addr};
               end
               st_data:
               begin
                  addr <= addr_inc;
                  if (rd_frame)
                     reg_rd <= '{valid: 1'b1, addr: addr_inc};
                  else
                     reg_wr <= '{valid: 1'b1, addr: addr, data: rx_byte};
               end
               // no frame open, stray bytes dropped
               default:
                  state <= st_idle;
            endcase
      end

endmodule

/* hdl/spi_slave_io.sv */
// spi slave pin interface, synchronizes pins and shifts bytes in and out
`timescale 1ns/1ns

module spi_slave_io
(
   input  logic          spi_clk,
   input  logic          nreset,
   input  logic          sck,
   input  logic          ss,
   input  logic          mosi,
   output logic          miso,
   output logic          frame_start,
   output logic          byte_done,
   output logic [7:0]    rx_byte,
   input  logic          tx_load,
   input  logic [7:0]    tx_byte
);

   // pins sampled together
   typedef struct packed
   {
      logic sck;
      logic ss;
      logic mosi;
   } pins_t;

   pins_t        pin_s1;
   pins_t        pin_s2;
   logic         sck_d;
   logic         ss_d;
   logic         sck_rise;
   logic         sck_fall;
   logic         ss_fall;
   logic [2:0]   bit_cnt;
   logic [7:0]   rx_shift;
   logic [7:0]   rx_next;
   logic [7:0]   tx_hold;
   logic [7:0]   tx_shift;

   //##########################################################################
   // synchronizer and edge detect
   //##########################################################################

   // ss idles high so no false frame start out of reset
   always_ff @(posedge spi_clk or negedge nreset)
      if (!nreset)
      begin
         pin_s1 <= '{sck: 1'b0, ss: 1'b1, mosi: 1'b0};
         pin_s2 <= '{sck: 1'b0, ss: 1'b1, mosi: 1'b0};
         sck_d  <= 1'b0;
         ss_d   <= 1'b1;
      end
      else
      begin
         pin_s1 <= '{sck: sck, ss: ss, mosi: mosi};
         pin_s2 <= pin_s1;
         sck_d  <= pin_s2.sck;
         ss_d   <= pin_s2.ss;
      end

   assign sck_rise = pin_s2.sck & ~sck_d;
   assign sck_fall = ~pin_s2.sck & sck_d;
   assign ss_fall  = ~pin_s2.ss & ss_d;

   // msb first
   assign rx_next  = {rx_shift[6:0], pin_s2.mosi};

   //##########################################################################
   // receive side
   //##########################################################################

   // ss high drops any partial byte
   always_ff @(posedge spi_clk or negedge nreset)
      if (!nreset)
      begin
         bit_cnt     <= 3'd0;
         byte_done   <= 1'b0;
         frame_start <= 1'b0;
      end
      else
      begin
         frame_start <= ss_fall;
         byte_done   <= ~pin_s2.ss & sck_rise & (bit_cnt == 3'd7);
         if (pin_s2.ss)
            bit_cnt <= 3'd0;
         else if (sck_rise)
            bit_cnt <= bit_cnt + 3'd1;
      end

   // receive shift register and completed byte
   always_ff @(posedge spi_clk)
      if (sck_rise)
      begin
         rx_shift <= rx_next;
         if (bit_cnt == 3'd7)
            rx_byte <= rx_next;
      end

   //##########################################################################
   // transmit side
   //##########################################################################

   // read data follows reg_rd by one cycle, tx_load by one more
   always_ff @(posedge spi_clk)
      tx_hold <= tx_byte;

   // miso moves on falling sck only, master samples on rising
   always_ff @(posedge spi_clk or negedge nreset)
      if (!nreset)
      begin
         tx_shift <= 8'h00;
         miso     <= 1'b0;
      end
      else if (pin_s2.ss)
      begin
         tx_shift <= 8'h00;
         miso     <= 1'b0;
      end
      else
      begin
         if (sck_fall)
            miso <= tx_shift[7];
         if (tx_load)
            tx_shift <= tx_hold;
         else if (sck_fall)
            tx_shift <= {tx_shift[6:0], 1'b0};
      end

endmodule

/* hdl/spi_core_pkg.sv */
// types for the core writeback port of the spi slave
`include "spi_slave_macros.svh"

package spi_core_pkg;

   //##########################################################################
   // core writeback packet
   //##########################################################################

   // only write, source address and data are kept
   // the rest of the mesh packet is not carried here
   typedef struct packed
   {
      // packet is a write, otherwise ignored
      logic                   write;
      // lands in registers 12 to 15
      logic [`CORE_AW-1:0]    srcaddr;
      // lands in registers 8 to 11
      logic [`CORE_AW-1:0]    data;
   } core_pkt_t;

   // register file keeps srcaddr above data
   // so data sits at the lowest core register
   // 65 bits in all

   // usage
   // core_access is a single cycle strobe
   // core_packet only looked at while it is high
   // no acknowledge goes back to the core

endpackage

/* hdl/spi_bus_pkg.sv */
// types for the spi side of the slave, frame header and register requests
`include "spi_slave_macros.svh"

package spi_bus_pkg;

   //##########################################################################
   // frame header
   //##########################################################################

   // first byte of every frame
   // rd set means the master reads from addr onward
   typedef struct packed
   {
      logic                   rd;
      logic                   spare;
      logic [`SPI_AW-1:0]     addr;
   } spi_hdr_t;

   //##########################################################################
   // register file requests
   //##########################################################################

   // one byte write, applied on the next clock
   typedef struct packed
   {
      logic                   valid;
      logic [`SPI_AW-1:0]     addr;
      logic [7:0]             data;
   } reg_wr_t;

   // read strobe, data comes back in the same cycle
   typedef struct packed
   {
      logic                   valid;
      logic [`SPI_AW-1:0]     addr;
   } reg_rd_t;

endpackage

/* hdl/spi_slave_macros.svh */
// spi slave register map addresses, register count and field widths
`ifndef SPI_SLAVE_MACROS_SVH
`define SPI_SLAVE_MACROS_SVH

//##########################################################################
// register space
//##########################################################################

// 64 byte wide registers behind the port
`define SPI_NREGS 64
`define SPI_AW 6

// fixed control registers
`define SPI_CONFIG 0
`define SPI_STATUS 1
`define SPI_CMD 2
`define SPI_PSIZE 3

// core writeback window and user space
`define SPI_CORE_BASE 8
`define SPI_USER_BASE 16

// packet width in bytes seen by the core
`define SPI_PSIZE_RESET 104

// core side address width
`define CORE_AW 32

// config bit positions
`define CONFIG_USER_EN 0
`define CONFIG_SPI_DIS 1

`endif
